// File: verilog/floo_pkg.sv
/*
 * floo merge package
 * flit width, the shared flit struct and the link state encodings
 */

`default_nettype none

package floo_pkg;

  // payload width of one flit
  localparam int FlitWidth = 32;

  // seq is carried through untouched and only read by the bench
  typedef struct packed {
    logic [FlitWidth-1:0] payload;
    logic [7:0]           seq;
  } flit_t;

  // input link receiver states
  typedef enum logic {
    RX_IDLE,
    RX_ACK
  } rx_state_e;

  // output link sender states
  typedef enum logic [1:0] {
    TX_IDLE,
    TX_REQ,
    TX_RELEASE
  } tx_state_e;

endpackage

`default_nettype wire

// File: verilog/floo_link_rx.sv
/*
 * floo link receiver
 * four-phase req/ack input link, one queue write per handshake
 */

`timescale 1ns/1ps
`default_nettype none

module floo_link_rx import floo_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  req_i,
  input  flit_t flit_i,
  output logic  ack_o,
  input  logic  full_i,
  output logic  wr_en_o,
  output flit_t wr_flit_o
);

  rx_state_e state_q;
  rx_state_e state_d;

  always_comb begin
    state_d = state_q;
    wr_en_o = 1'b0;
    unique case (state_q)
      RX_IDLE: begin
        // hold off while the queue is full so the sender keeps its flit
        if (req_i && !full_i) begin
          wr_en_o = 1'b1;
          state_d = RX_ACK;
        end
      end
      RX_ACK: begin
        // wait for the sender to drop req before releasing ack
        if (!req_i) begin
          state_d = RX_IDLE;
        end
      end
      default: begin
        state_d = RX_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= RX_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // ack follows the write by one cycle
  assign ack_o = (state_q == RX_ACK);

  // flit is stable while req is high, so it goes straight to the queue
  assign wr_flit_o = flit_i;

endmodule

`default_nettype wire

// File: verilog/floo_flit_fifo.sv
/*
 * floo flit fifo
 * per-input circular flit queue with full and empty flags
 * whose head output always shows the oldest entry
 */

`timescale 1ns/1ps
`default_nettype none

module floo_flit_fifo import floo_pkg::*; #(
  parameter int FifoDepth = 4,
  localparam int PtrWidth = (FifoDepth > 1) ? $clog2(FifoDepth) : 1,
  localparam int CntWidth = $clog2(FifoDepth + 1)
) (
  input  logic  clk,
  input  logic  rst_n,
  input  logic  wr_en_i,
  input  flit_t wr_flit_i,
  output logic  full_o,
  input  logic  rd_en_i,
  output flit_t head_flit_o,
  output logic  empty_o
);

  flit_t               mem_q [FifoDepth];
  logic [PtrWidth-1:0] wr_ptr_q;
  logic [PtrWidth-1:0] rd_ptr_q;
  logic [CntWidth-1:0] count_q;
  logic                do_write;
  logic                do_read;

  // pointer step with an explicit wrap that also works for a depth of one
  function automatic logic [PtrWidth-1:0] ptr_inc(input logic [PtrWidth-1:0] ptr);
    if (ptr == PtrWidth'(FifoDepth - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign full_o   = (count_q == CntWidth'(FifoDepth));
  assign empty_o  = (count_q == '0);
  assign do_write = wr_en_i && !full_o;
  assign do_read  = rd_en_i && !empty_o;

  assign head_flit_o = mem_q[rd_ptr_q];

  // storage array
  always_ff @(posedge clk) begin
    if (do_write) begin
      mem_q[wr_ptr_q] <= wr_flit_i;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_write) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (do_read) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
      end
      // write and pop in the same cycle leave the count alone
      unique case ({do_write, do_read})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: verilog/floo_rr_arbiter.sv
/*
 * floo round-robin arbiter
 * one-hot and index encoded grant whose priority pointer
 * only moves when update_i reports that the grant was used
 */

`timescale 1ns/1ps
`default_nettype none

module floo_rr_arbiter #(
  parameter int NumInputs = 4,
  localparam int IdxWidth = (NumInputs > 1) ? $clog2(NumInputs) : 1
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic [NumInputs-1:0] req_i,
  input  logic                 update_i,
  output logic [NumInputs-1:0] grant_o,
  output logic [IdxWidth-1:0]  grant_id_o
);

  if (NumInputs == 1) begin : gen_single

    // nothing to arbitrate
    assign grant_o    = req_i;
    assign grant_id_o = '0;

  end else begin : gen_rr

    logic [IdxWidth-1:0]    ptr_q;
    logic [IdxWidth-1:0]    ptr_d;
    logic [2*NumInputs-1:0] req_dbl;
    logic [NumInputs-1:0]   req_rot;
    logic [NumInputs-1:0]   sel_rot;
    logic [2*NumInputs-1:0] sel_dbl;
    logic [NumInputs-1:0]   grant;
    logic [IdxWidth-1:0]    grant_id;
    logic [NumInputs-1:0]   id_mask [IdxWidth];

    // rotate right so that input ptr_q lands on bit 0
    assign req_dbl = {req_i, req_i} >> ptr_q;
    assign req_rot = req_dbl[NumInputs-1:0];

    // lowest set bit wins as req & -req
    assign sel_rot = req_rot & (~req_rot + 1'b1);

    // rotate the winner back to its input position
    assign sel_dbl = {sel_rot, sel_rot} << ptr_q;
    assign grant   = sel_dbl[2*NumInputs-1 -: NumInputs];

    // id_mask[b] has bit j set when bit b of j is one
    for (genvar b = 0; b < IdxWidth; b++) begin : gen_id
      for (genvar j = 0; j < NumInputs; j++) begin : gen_mask
        assign id_mask[b][j] = (((j >> b) % 2) == 1);
      end
      assign grant_id[b] = |(grant & id_mask[b]);
    end

    // the input after the granted one gets top priority next
    assign ptr_d = (grant_id == IdxWidth'(NumInputs - 1)) ? '0 : grant_id + 1'b1;

    always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
        ptr_q <= '0;
      end else if (update_i) begin
        ptr_q <= ptr_d;
      end
    end

    assign grant_o    = grant;
    assign grant_id_o = grant_id;

  end

endmodule

`default_nettype wire

// File: verilog/floo_link_tx.sv
/*
 * floo link sender
 * commits one arbitration result per transfer and drives
 * the flit and its source index over a four-phase output link
 */

`timescale 1ns/1ps
`default_nettype none

module floo_link_tx import floo_pkg::*; #(
  parameter int NumInputs = 4,
  localparam int IdxWidth = (NumInputs > 1) ? $clog2(NumInputs) : 1
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic [IdxWidth-1:0]  grant_id_i,
  input  logic                 any_req_i,
  input  flit_t                head_flits_i [NumInputs],
  output logic [NumInputs-1:0] pop_o,
  output logic                 update_o,
  output logic                 req_o,
  output flit_t                flit_o,
  output logic [IdxWidth-1:0]  src_o,
  input  logic                 ack_i
);

  tx_state_e           state_q;
  tx_state_e           state_d;
  flit_t               flit_q;
  logic [IdxWidth-1:0] src_q;
  logic                commit;

  always_comb begin
    state_d = state_q;
    commit  = 1'b0;
    unique case (state_q)
      TX_IDLE: begin
        if (any_req_i) begin
          commit  = 1'b1;
          state_d = TX_REQ;
        end
      end
      TX_REQ: begin
        if (ack_i) begin
          state_d = TX_RELEASE;
        end
      end
      TX_RELEASE: begin
        // req is low, wait for the receiver to finish the handshake
        if (!ack_i) begin
          state_d = TX_IDLE;
        end
      end
      default: begin
        state_d = TX_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= TX_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // flit and index are taken together on the commit edge
  always_ff @(posedge clk) begin
    if (commit) begin
      flit_q <= head_flits_i[grant_id_i];
      src_q  <= grant_id_i;
    end
  end

  assign pop_o    = commit ? (NumInputs'(1) << grant_id_i) : '0;
  assign update_o = commit;
  assign req_o    = (state_q == TX_REQ);
  assign flit_o   = flit_q;
  assign src_o    = src_q;

endmodule

`default_nettype wire

// File: verilog/floo_merge_top.sv
/*
 * floo merge top
 * NumInputs four-phase input links with their queues,
 * merged by a round-robin arbiter onto one output link
 */

`timescale 1ns/1ps
`default_nettype none

module floo_merge_top import floo_pkg::*; #(
  parameter int NumInputs = 4,
  parameter int FifoDepth = 4,
  localparam int IdxWidth = (NumInputs > 1) ? $clog2(NumInputs) : 1
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic [NumInputs-1:0] in_req_i,
  input  flit_t                in_flit_i [NumInputs],
  output logic [NumInputs-1:0] in_ack_o,
  output logic                 out_req_o,
  output flit_t                out_flit_o,
  output logic [IdxWidth-1:0]  out_src_o,
  input  logic                 out_ack_i
);

  // per-input queue signals
  logic [NumInputs-1:0] fifo_wr_en;
  flit_t                fifo_wr_flit [NumInputs];
  logic [NumInputs-1:0] fifo_full;
  logic [NumInputs-1:0] fifo_empty;
  logic [NumInputs-1:0] fifo_pop;
  flit_t                fifo_head [NumInputs];

  // arbitration signals
  logic [NumInputs-1:0] arb_req;
  logic [NumInputs-1:0] arb_grant;
  logic [IdxWidth-1:0]  arb_grant_id;
  logic                 arb_update;
  logic                 any_req;

  for (genvar k = 0; k < NumInputs; k++) begin : gen_input

    floo_link_rx u_link_rx (
      .clk       (clk),
      .rst_n     (rst_n),
      .req_i     (in_req_i[k]),
      .flit_i    (in_flit_i[k]),
      .ack_o     (in_ack_o[k]),
      .full_i    (fifo_full[k]),
      .wr_en_o   (fifo_wr_en[k]),
      .wr_flit_o (fifo_wr_flit[k])
    );

    floo_flit_fifo #(
      .FifoDepth (FifoDepth)
    ) u_flit_fifo (
      .clk         (clk),
      .rst_n       (rst_n),
      .wr_en_i     (fifo_wr_en[k]),
      .wr_flit_i   (fifo_wr_flit[k]),
      .full_o      (fifo_full[k]),
      .rd_en_i     (fifo_pop[k]),
      .head_flit_o (fifo_head[k]),
      .empty_o     (fifo_empty[k])
    );

  end

  // every non-empty queue requests the output
  assign arb_req = ~fifo_empty;
  assign any_req = |arb_req;

  floo_rr_arbiter #(
    .NumInputs (NumInputs)
  ) u_rr_arbiter (
    .clk        (clk),
    .rst_n      (rst_n),
    .req_i      (arb_req),
    .update_i   (arb_update),
    .grant_o    (arb_grant),
    .grant_id_o (arb_grant_id)
  );

  floo_link_tx #(
    .NumInputs (NumInputs)
  ) u_link_tx (
    .clk          (clk),
    .rst_n        (rst_n),
    .grant_id_i   (arb_grant_id),
    .any_req_i    (any_req),
    .head_flits_i (fifo_head),
    .pop_o        (fifo_pop),
    .update_o     (arb_update),
    .req_o        (out_req_o),
    .flit_o       (out_flit_o),
    .src_o        (out_src_o),
    .ack_i        (out_ack_i)
  );

endmodule

`default_nettype wire

// File: bench/floo_merge_monitor.sv
/*
 * floo merge monitor
 * watches both link sides, predicts the round-robin source order
 * and checks every accepted output flit against the sent flits
 */

`timescale 1ns/1ps
`default_nettype none

module floo_merge_monitor import floo_pkg::*; #(
  parameter int NumInputs = 4,
  localparam int IdxWidth = (NumInputs > 1) ? $clog2(NumInputs) : 1
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic [NumInputs-1:0] in_req_i,
  input  logic [NumInputs-1:0] in_ack_i,
  input  flit_t                in_flit_i [NumInputs],
  input  logic                 out_req_i,
  input  logic                 out_ack_i,
  input  flit_t                out_flit_i,
  input  logic [IdxWidth-1:0]  out_src_i,
  output int                   err_count_o,
  output int                   recv_count_o
);

  flit_t                exp_q [NumInputs][$];
  int                   pending [NumInputs];
  int                   last_src;
  int                   exp_src;
  int                   errs;
  int                   recvs;
  logic                 prev_req;
  logic [NumInputs-1:0] prev_ack;
  logic [NumInputs-1:0] pend_mask;
  flit_t                exp_flit;

  // first pending input after the last granted one
  function automatic int expected_source(input logic [NumInputs-1:0] pend, input int last);
    int idx;
    for (int i = 1; i <= NumInputs; i++) begin
      idx = (last + i) % NumInputs;
      if (pend[idx]) begin
        return idx;
      end
    end
    return -1;
  endfunction

  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int k = 0; k < NumInputs; k++) begin
        pending[k] = 0;
        exp_q[k].delete();
      end
      last_src     = NumInputs - 1;
      exp_src      = -1;
      errs         = 0;
      recvs        = 0;
      prev_req     = 1'b0;
      prev_ack     = '0;
      err_count_o  <= 0;
      recv_count_o <= 0;
    end else begin
      for (int k = 0; k < NumInputs; k++) begin
        pend_mask[k] = (pending[k] != 0);
      end
      // a req edge means the sender committed on the previous clock
      if (out_req_i && !prev_req) begin
        exp_src = expected_source(pend_mask, last_src);
        if (exp_src < 0) begin
          errs++;
          $display("out_req_o rose while no flit was queued");
        end else begin
          pending[exp_src]--;
          last_src = exp_src;
        end
      end
      if (out_req_i && out_ack_i) begin
        recvs++;
        if (int'(out_src_i) != exp_src) begin
          errs++;
          $display("Error: out_src_o expected %h got %h", exp_src[IdxWidth-1:0], out_src_i);
        end
        if (exp_q[out_src_i].size() == 0) begin
          errs++;
          $display("a flit arrived from input %0d that was never sent", out_src_i);
        end else begin
          exp_flit = exp_q[out_src_i].pop_front();
          if (out_flit_i != exp_flit) begin
            errs++;
            $display("Error: out_flit_o expected %h got %h", exp_flit, out_flit_i);
          end
        end
      end
      // ack edge marks the queue write of the clock before
      for (int k = 0; k < NumInputs; k++) begin
        if (in_ack_i[k] && !prev_ack[k]) begin
          if (!in_req_i[k]) begin
            errs++;
            $display("in_ack_o[%0d] rose without a request", k);
          end
          pending[k]++;
          exp_q[k].push_back(in_flit_i[k]);
        end
      end
      prev_req     = out_req_i;
      prev_ack     = in_ack_i;
      err_count_o  <= errs;
      recv_count_o <= recvs;
    end
  end

endmodule

`default_nettype wire

// File: bench/floo_merge_chk.sv
/*
 * floo merge checker
 * concurrent assertions on the four-phase links and the grant vector
 */

`timescale 1ns/1ps
`default_nettype none

module floo_merge_chk import floo_pkg::*; #(
  parameter int NumInputs = 4
) (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic [NumInputs-1:0] in_req_i,
  input  logic [NumInputs-1:0] in_ack_o,
  input  logic                 out_req_o,
  input  flit_t                out_flit_o,
  input  logic                 out_ack_i,
  input  logic [NumInputs-1:0] arb_req,
  input  logic [NumInputs-1:0] arb_grant
);

  out_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
    out_req_o && !out_ack_i |=> out_req_o && $stable(out_flit_o))
    else $error("output req or flit changed before ack");

  out_req_rise_a: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(out_req_o) |-> !out_ack_i)
    else $error("output req rose while ack was still high");

  grant_onehot_a: assert property (@(posedge clk) disable iff (!rst_n)
    arb_req != '0 |-> $onehot(arb_grant))
    else $error("arbiter grant is not one-hot");

  for (genvar k = 0; k < NumInputs; k++) begin : gen_in_ack
    in_ack_rise_a: assert property (@(posedge clk) disable iff (!rst_n)
      $rose(in_ack_o[k]) |-> in_req_i[k])
      else $error("input ack rose while its req was low");
  end

endmodule

bind floo_merge_top floo_merge_chk #(
  .NumInputs (NumInputs)
) u_chk (
  .clk        (clk),
  .rst_n      (rst_n),
  .in_req_i   (in_req_i),
  .in_ack_o   (in_ack_o),
  .out_req_o  (out_req_o),
  .out_flit_o (out_flit_o),
  .out_ack_i  (out_ack_i),
  .arb_req    (arb_req),
  .arb_grant  (arb_grant)
);

`default_nettype wire

// File: bench/tb_floo_merge.sv
/*
 * floo merge testbench
 * drives the input links, answers the output link and runs
 * the directed and random traffic phases
 */

`timescale 1ns/1ps
`default_nettype none

module tb_floo_merge import floo_pkg::*; ();

  localparam int NumInputs = 4;
  localparam int FifoDepth = 4;
  localparam int IdxWidth  = 2;

  logic                 clk = 1'b0;
  logic                 rst_n = 1'b0;
  logic [NumInputs-1:0] in_req = '0;
  flit_t                in_flit [NumInputs] = '{default: '0};
  logic [NumInputs-1:0] in_ack;
  logic                 out_req;
  flit_t                out_flit;
  logic [IdxWidth-1:0]  out_src;
  logic                 out_ack = 1'b0;

  // traffic control, set by the test sequence
  int   target [NumInputs] = '{default: 0};
  logic gap_en = 1'b0;
  logic delay_en = 1'b0;
  logic hold_out = 1'b0;

  int          sent [NumInputs];
  int          delay_cnt;
  logic [15:0] lfsr_q = 16'd53087;
  int          mon_errs;
  int          recv_count;
  int          bench_errs = 0;
  int          total_flits = 0;
  logic        timed_out = 1'b0;

  always #5 clk = ~clk;

  floo_merge_top #(
    .NumInputs (NumInputs),
    .FifoDepth (FifoDepth)
  ) uut (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_req_i   (in_req),
    .in_flit_i  (in_flit),
    .in_ack_o   (in_ack),
    .out_req_o  (out_req),
    .out_flit_o (out_flit),
    .out_src_o  (out_src),
    .out_ack_i  (out_ack)
  );

  floo_merge_monitor #(
    .NumInputs (NumInputs)
  ) u_monitor (
    .clk          (clk),
    .rst_n        (rst_n),
    .in_req_i     (in_req),
    .in_ack_i     (in_ack),
    .in_flit_i    (in_flit),
    .out_req_i    (out_req),
    .out_ack_i    (out_ack),
    .out_flit_i   (out_flit),
    .out_src_i    (out_src),
    .err_count_o  (mon_errs),
    .recv_count_o (recv_count)
  );

  // galois lfsr with one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 16'hB400) : (lfsr_q >> 1);
      r = {r[30:0], lfsr_q[0]};
    end
    return r;
  endfunction

  // input link senders and output link responder
  always @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      in_req    <= '0;
      out_ack   <= 1'b0;
      delay_cnt <= 0;
      for (int k = 0; k < NumInputs; k++) begin
        sent[k]    <= 0;
        in_flit[k] <= '0;
      end
    end else begin
      for (int k = 0; k < NumInputs; k++) begin
        if (in_req[k]) begin
          if (in_ack[k]) begin
            in_req[k] <= 1'b0;
          end
        end else if (!in_ack[k] && sent[k] != target[k] && (!gap_en || rand_bits(2) == 0)) begin
          in_flit[k] <= '{payload: rand_bits(FlitWidth), seq: sent[k][7:0]};
          in_req[k]  <= 1'b1;
          sent[k]    <= sent[k] + 1;
        end
      end
      if (out_ack) begin
        if (!out_req) begin
          out_ack <= 1'b0;
        end
      end else if (out_req && !hold_out) begin
        if (delay_cnt == 0) begin
          out_ack   <= 1'b1;
          delay_cnt <= delay_en ? int'(rand_bits(3)) : 0;
        end else begin
          delay_cnt <= delay_cnt - 1;
        end
      end
    end
  end

  task automatic wait_sent(input int max_cycles, output logic ok);
    int cycles;
    cycles = 0;
    ok = 1'b0;
    while (!ok && cycles < max_cycles) begin
      @(posedge clk);
      ok = 1'b1;
      for (int k = 0; k < NumInputs; k++) begin
        if (sent[k] != target[k]) begin
          ok = 1'b0;
        end
      end
      cycles++;
    end
    if (!ok) begin
      $display("timeout: the inputs did not offer all flits within %0d cycles", max_cycles);
      timed_out = 1'b1;
    end
  endtask

  task automatic wait_drained(input int max_cycles, output logic ok);
    int cycles;
    cycles = 0;
    ok = 1'b0;
    while (!ok && cycles < max_cycles) begin
      @(posedge clk);
      ok = (recv_count == total_flits) && (in_req == '0) && !out_req;
      cycles++;
    end
    if (!ok) begin
      $display("timeout: only %0d of %0d flits left the output", recv_count, total_flits);
      timed_out = 1'b1;
    end
  endtask

  task automatic run_tests();
    logic ok;
    // stay idle after reset while the monitor flags any spurious req or ack
    repeat (10) @(posedge clk);
    // backlog all four inputs and then serve from the reset pointer
    hold_out <= 1'b1;
    for (int k = 0; k < NumInputs; k++) begin
      target[k] <= target[k] + 4;
    end
    total_flits += 4 * NumInputs;
    wait_sent(300, ok);
    if (!ok) return;
    hold_out <= 1'b0;
    wait_drained(500, ok);
    if (!ok) return;
    // single flit on input 2
    target[2] <= target[2] + 1;
    total_flits += 1;
    wait_drained(100, ok);
    if (!ok) return;
    // only inputs 1 and 3 backlogged
    hold_out  <= 1'b1;
    target[1] <= target[1] + 3;
    target[3] <= target[3] + 3;
    total_flits += 6;
    wait_sent(300, ok);
    if (!ok) return;
    hold_out <= 1'b0;
    wait_drained(500, ok);
    if (!ok) return;
    // stall the output with one flit in the sender and a full queue behind it
    hold_out  <= 1'b1;
    target[1] <= target[1] + FifoDepth + 2;
    total_flits += FifoDepth + 2;
    wait_sent(300, ok);
    if (!ok) return;
    repeat (20) begin
      @(posedge clk);
      if (in_ack[1]) begin
        bench_errs++;
        $display("Error: in_ack_o[1] expected %h got %h", 1'b0, in_ack[1]);
      end
    end
    hold_out <= 1'b0;
    wait_drained(500, ok);
    if (!ok) return;
    // random traffic with random output ack delays
    gap_en   <= 1'b1;
    delay_en <= 1'b1;
    for (int k = 0; k < NumInputs; k++) begin
      target[k] <= target[k] + 75;
    end
    total_flits += 75 * NumInputs;
    wait_drained(20000, ok);
  endtask

  task automatic finish_run();
    $display("errors: monitor %0d, bench %0d, flits received %0d of %0d",
             mon_errs, bench_errs, recv_count, total_flits);
    if (mon_errs == 0 && bench_errs == 0 && !timed_out && recv_count == total_flits) begin
      $display("Verification passed");
    end else begin
      $display("Verification failed");
    end
    $finish;
  endtask

  initial begin
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    run_tests();
    finish_run();
  end

endmodule

`default_nettype wire

// File: list.f
verilog/floo_pkg.sv
verilog/floo_link_rx.sv
verilog/floo_flit_fifo.sv
verilog/floo_rr_arbiter.sv
verilog/floo_link_tx.sv
verilog/floo_merge_top.sv
bench/floo_merge_monitor.sv
bench/floo_merge_chk.sv
bench/tb_floo_merge.sv

// File: Makefile
# Verilator build and run for the floo merge testbench

VERILATOR ?= verilator
TOP       ?= tb_floo_merge
FILE_LIST ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell grep -v '^+' $(FILE_LIST))

.PHONY: all run check clean

all: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; cat $(LOG)
	grep -q "Verification passed" $(LOG)

check:
	grep -q "Verification passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
